// File: source/cpuControlPkg.sv
package cpuControlPkg;

  localparam int instrWidth = 32;
  localparam int opcodeWidth = 6;
  localparam int functWidth = 6;
  localparam int aluOpWidth = 5;

  // Primary opcodes, standard MIPS encodings
  typedef enum logic [opcodeWidth-1:0] {
    opRType = 6'd0,
    opJ     = 6'd2,  opJal   = 6'd3,
    opBeq   = 6'd4,  opBne   = 6'd5,  opBlez  = 6'd6,  opBgtz = 6'd7,
    opAddiu = 6'd9,  opSlti  = 6'd10, opSltiu = 6'd11,
    opAndi  = 6'd12, opOri   = 6'd13, opXori  = 6'd14, opLui  = 6'd15,
    opLb    = 6'd32, opLh    = 6'd33, opLw    = 6'd35,
    opLbu   = 6'd36, opLhu   = 6'd37,
    opSb    = 6'd40, opSh    = 6'd41, opSw    = 6'd43
  } opcode_e;

  typedef enum logic [functWidth-1:0] {
    fnJr   = 6'd8,
    fnAddu = 6'd33,
    fnAnd  = 6'd36,
    fnOr   = 6'd37
  } funct_e;

  typedef struct packed {
    logic [opcodeWidth-1:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [functWidth-1:0] funct;
  } rFields_s;

  // Immediate takes what is left after opcode, rs and rt
  typedef struct packed {
    logic [opcodeWidth-1:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [instrWidth-opcodeWidth-11:0] imm16;
  } iFields_s;

  typedef union packed {
    rFields_s rFields;
    iFields_s iFields;
  } instrWord_u;

  typedef enum logic [aluOpWidth-1:0] {
    aluAnd = 5'd0, aluOr = 5'd1, aluAdd = 5'd2, aluXor = 5'd3,
    aluSlt = 5'd7, aluSltu = 5'd9, aluEq = 5'd10,
    aluBranchTarget = 5'd13, aluPassA = 5'd14, aluFunct = 5'd15,
    aluLez = 5'd16, aluJumpTarget = 5'd17, aluLui = 5'd20
  } aluOp_e;

  typedef enum logic [1:0] {
    srcBReg = 2'd0, srcBFour = 2'd1, srcBImm = 2'd2, srcBImmShift = 2'd3
  } srcB_e;

  typedef enum logic [2:0] {
    fetch = 3'd0, decode = 3'd1, exec1 = 3'd2, exec2 = 3'd3,
    exec3 = 3'd4, halted = 3'd5, stall = 3'd6
  } state_e;

  typedef enum logic [3:0] {
    clsAluReg, clsAluImm, clsSltImm, clsLui, clsLoad,
    clsStore, clsBranch, clsJump, clsJumpLink, clsJumpReg
  } instrClass_e;

  typedef enum logic [1:0] {widthWord, widthHalf, widthByte} memWidth_e;

  typedef enum logic [1:0] {
    extZero = 2'd0, extByteSigned = 2'd2, extHalfSigned = 2'd3
  } extMode_e;

endpackage

// File: source/instrClassify.sv
`timescale 1ns/100ps

module instrClassify (
  input  cpuControlPkg::instrWord_u instr,
  output cpuControlPkg::instrClass_e instrClass,
  output cpuControlPkg::memWidth_e memWidth,
  output logic loadSigned,
  output cpuControlPkg::aluOp_e aluOpImm,
  output cpuControlPkg::opcode_e branchKind
);
  import cpuControlPkg::*;

  // Branch condition logic only looks at this for clsBranch
  assign branchKind = opcode_e'(instr.iFields.opcode);

  always_comb begin
    instrClass = clsAluReg;
    memWidth = widthWord;
    loadSigned = 1'b0;
    aluOpImm = aluAdd;
    case (instr.iFields.opcode)
      opRType: begin
        if (instr.rFields.funct == fnJr) begin
          instrClass = clsJumpReg;
        end
      end
      opAddiu: instrClass = clsAluImm;
      opAndi: begin
        instrClass = clsAluImm;
        aluOpImm = aluAnd;
      end
      opOri: begin
        instrClass = clsAluImm;
        aluOpImm = aluOr;
      end
      opXori: begin
        instrClass = clsAluImm;
        aluOpImm = aluXor;
      end
      opSlti: begin
        instrClass = clsSltImm;
        aluOpImm = aluSlt;
      end
      opSltiu: begin
        instrClass = clsSltImm;
        aluOpImm = aluSltu;
      end
      opLui: begin
        instrClass = clsLui;
        aluOpImm = aluLui;
      end
      opLw: instrClass = clsLoad;
      opLh, opLhu: begin
        instrClass = clsLoad;
        memWidth = widthHalf;
        loadSigned = (instr.iFields.opcode == opLh);
      end
      opLb, opLbu: begin
        instrClass = clsLoad;
        memWidth = widthByte;
        loadSigned = (instr.iFields.opcode == opLb);
      end
      opSw: instrClass = clsStore;
      opSh: begin
        instrClass = clsStore;
        memWidth = widthHalf;
      end
      opSb: begin
        instrClass = clsStore;
        memWidth = widthByte;
      end
      opBeq, opBne: begin
        instrClass = clsBranch;
        aluOpImm = aluEq;
      end
      opBlez, opBgtz: begin
        instrClass = clsBranch;
        aluOpImm = aluLez;
      end
      opJ: instrClass = clsJump;
      opJal: instrClass = clsJumpLink;
      // Unknown opcodes fall back to a harmless register op
      default: instrClass = clsAluReg;
    endcase
  end

endmodule

// File: source/controlFsm.sv
`timescale 1ns/100ps

module controlFsm (
  input  logic clk,
  input  logic arstN,
  input  cpuControlPkg::instrClass_e instrClass,
  input  logic execStall,
  input  logic waitrequest,
  input  logic pcIsZero,
  input  logic run,
  output cpuControlPkg::state_e state,
  output logic execLast,
  output logic active,
  output logic pcWrite,
  output logic irWrite,
  output logic irSel,
  output logic fetchRetry
);
  import cpuControlPkg::*;

  state_e stateNext;
  state_e lastExec;
  state_e doneState;
  logic haltLatch;

  // Number of exec cycles depends on the class
  always_comb begin
    case (instrClass)
      clsBranch, clsJump, clsJumpReg: lastExec = exec1;
      clsLoad: lastExec = exec3;
      default: lastExec = exec2;
    endcase
  end

  assign execLast = (state == lastExec);
  assign doneState = haltLatch ? halted : fetch;

  always_comb begin
    stateNext = state;
    case (state)
      fetch, stall: stateNext = waitrequest ? stall : decode;
      decode: stateNext = exec1;
      exec1: begin
        if (!execStall) begin
          stateNext = execLast ? doneState : exec2;
        end
      end
      exec2: begin
        if (!waitrequest) begin
          stateNext = execLast ? doneState : exec3;
        end
      end
      exec3: stateNext = doneState;
      halted: begin
        if (run) begin
          stateNext = fetch;
        end
      end
      default: stateNext = halted;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= halted;
      haltLatch <= 1'b0;
    end else begin
      state <= stateNext;
      // Remember whether this instruction came from PC zero
      if (state == fetch) begin
        haltLatch <= pcIsZero;
      end
    end
  end

  assign active = (state != halted);
  assign pcWrite = (state == fetch);
  assign irWrite = (state == decode);
  assign irSel = (state != decode);
  assign fetchRetry = (state == stall);

endmodule

// File: source/datapathSelect.sv
`timescale 1ns/100ps

module datapathSelect (
  input  cpuControlPkg::state_e state,
  input  cpuControlPkg::instrClass_e instrClass,
  input  cpuControlPkg::aluOp_e aluOpImm,
  output logic aluSrcA,
  output cpuControlPkg::srcB_e aluSrcB,
  output cpuControlPkg::aluOp_e aluControl,
  output logic aluSel,
  output logic extSel,
  output logic regWrite,
  output logic regDst,
  output logic memToReg,
  output logic link,
  output logic isJump
);
  import cpuControlPkg::*;

  logic isJumpClass;
  logic isAluClass;
  logic isMemClass;

  assign isJumpClass = (instrClass == clsJump) || (instrClass == clsJumpLink);
  assign isAluClass = (instrClass == clsAluReg) || (instrClass == clsAluImm) ||
                      (instrClass == clsSltImm) || (instrClass == clsLui);
  assign isMemClass = (instrClass == clsLoad) || (instrClass == clsStore);

  always_comb begin
    aluSrcA = 1'b0;
    aluSrcB = srcBReg;
    aluControl = aluAnd;
    aluSel = 1'b0;
    extSel = 1'b0;
    regWrite = 1'b0;
    regDst = 1'b0;
    memToReg = 1'b0;
    link = 1'b0;
    isJump = 1'b0;
    case (state)
      // PC + 4
      fetch: begin
        aluSrcB = srcBFour;
        aluControl = aluAdd;
      end
      // Precompute branch or jump target
      decode: begin
        aluSrcB = srcBImmShift;
        aluControl = isJumpClass ? aluJumpTarget : aluBranchTarget;
        extSel = isJumpClass;
      end
      exec1: begin
        if (isAluClass || isMemClass) begin
          aluSrcA = 1'b1;
          aluSrcB = (instrClass == clsAluReg) ? srcBReg : srcBImm;
          if (instrClass == clsAluReg) begin
            aluControl = aluFunct;
          end else if (isMemClass) begin
            aluControl = aluAdd;
          end else begin
            aluControl = aluOpImm;
          end
          extSel = (instrClass == clsAluImm);
        end
        case (instrClass)
          clsBranch: begin
            aluSrcA = 1'b1;
            aluSrcB = srcBReg;
            aluControl = aluOpImm;
            aluSel = 1'b1;
          end
          clsJump: begin
            aluSrcB = srcBImmShift;
            aluControl = aluJumpTarget;
            extSel = 1'b1;
            isJump = 1'b1;
          end
          clsJumpReg: begin
            aluSrcA = 1'b1;
            aluControl = aluPassA;
          end
          // Return address goes to the register file first
          clsJumpLink: begin
            aluSrcB = srcBFour;
            aluControl = aluAdd;
            regWrite = 1'b1;
            memToReg = 1'b1;
            link = 1'b1;
          end
          default: ;
        endcase
      end
      exec2: begin
        if (instrClass == clsJumpLink) begin
          aluSrcB = srcBImmShift;
          aluControl = aluJumpTarget;
          extSel = 1'b1;
          isJump = 1'b1;
        end else if (isAluClass) begin
          regWrite = 1'b1;
          memToReg = 1'b1;
          aluSel = 1'b1;
          regDst = (instrClass == clsAluReg);
        end
      end
      // Load data writeback
      exec3: regWrite = (instrClass == clsLoad);
      default: ;
    endcase
  end

endmodule

// File: source/memAccessDecode.sv
`timescale 1ns/100ps

module memAccessDecode (
  input  cpuControlPkg::state_e state,
  input  cpuControlPkg::instrClass_e instrClass,
  input  cpuControlPkg::memWidth_e memWidth,
  input  logic loadSigned,
  output logic iorD,
  output logic memRead,
  output logic memWrite,
  output logic [3:0] byteEnable,
  output cpuControlPkg::extMode_e extendedMem
);
  import cpuControlPkg::*;

  logic isLoad;
  logic isStore;
  logic inAccess;

  assign isLoad = (instrClass == clsLoad);
  assign isStore = (instrClass == clsStore);
  // Data side cycles, exec3 only exists for loads
  assign inAccess = (isLoad || isStore) && ((state == exec2) || (state == exec3));

  assign memRead = (state == fetch) || (state == stall) || (isLoad && (state == exec2));
  assign memWrite = isStore && (state == exec2);
  assign iorD = (isLoad || isStore) && (state == exec2);

  always_comb begin
    byteEnable = 4'b1111;
    extendedMem = extZero;
    if (inAccess) begin
      case (memWidth)
        widthByte: byteEnable = 4'b0001;
        widthHalf: byteEnable = 4'b0011;
        default: byteEnable = 4'b1111;
      endcase
      if (isLoad && loadSigned) begin
        if (memWidth == widthByte) begin
          extendedMem = extByteSigned;
        end else if (memWidth == widthHalf) begin
          extendedMem = extHalfSigned;
        end
      end
    end
  end

endmodule

// File: source/branchResolve.sv
`timescale 1ns/100ps

module branchResolve (
  input  logic clk,
  input  logic arstN,
  input  cpuControlPkg::state_e state,
  input  logic execLast,
  input  cpuControlPkg::instrClass_e instrClass,
  input  cpuControlPkg::opcode_e branchKind,
  input  logic outLsb,
  output logic branchDelay,
  output logic pcSrc
);
  import cpuControlPkg::*;

  logic taken;
  logic delayNext;

  // outLsb carries the ALU compare result
  always_comb begin
    case (branchKind)
      opBeq, opBlez: taken = outLsb;
      opBne, opBgtz: taken = !outLsb;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (instrClass)
      clsBranch: delayNext = taken;
      clsJump, clsJumpLink, clsJumpReg: delayNext = 1'b1;
      default: delayNext = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      branchDelay <= 1'b0;
    end else if (execLast) begin
      branchDelay <= delayNext;
    end
  end

  // Redirect only the next fetch
  assign pcSrc = branchDelay && (state == fetch);

endmodule

// File: source/cpuControl.sv
`timescale 1ns/100ps

module cpuControl (
  input  logic clk,
  input  logic arstN,
  input  cpuControlPkg::instrWord_u instr,
  input  logic execStall,
  input  logic waitrequest,
  input  logic outLsb,
  input  logic pcIsZero,
  input  logic run,
  output logic active,
  output cpuControlPkg::state_e state,
  output logic branchDelay,
  output logic pcWrite,
  output logic irWrite,
  output logic irSel,
  output logic iorD,
  output logic pcSrc,
  output logic fetchRetry,
  output logic memRead,
  output logic memWrite,
  output logic [3:0] byteEnable,
  output cpuControlPkg::extMode_e extendedMem,
  output logic aluSrcA,
  output cpuControlPkg::srcB_e aluSrcB,
  output cpuControlPkg::aluOp_e aluControl,
  output logic aluSel,
  output logic extSel,
  output logic regWrite,
  output logic regDst,
  output logic memToReg,
  output logic link,
  output logic isJump
);
  import cpuControlPkg::*;

  instrClass_e instrClass;
  memWidth_e memWidth;
  logic loadSigned;
  aluOp_e aluOpImm;
  opcode_e branchKind;
  logic execLast;

  // Instruction is classified once, the rest works from class and state
  instrClassify classify0 (.instr, .instrClass, .memWidth, .loadSigned, .aluOpImm, .branchKind);

  controlFsm fsm0 (.clk, .arstN, .instrClass, .execStall, .waitrequest, .pcIsZero, .run,
    .state, .execLast, .active, .pcWrite, .irWrite, .irSel, .fetchRetry);

  datapathSelect dpSel0 (.state, .instrClass, .aluOpImm, .aluSrcA, .aluSrcB, .aluControl,
    .aluSel, .extSel, .regWrite, .regDst, .memToReg, .link, .isJump);

  memAccessDecode memDec0 (.state, .instrClass, .memWidth, .loadSigned, .iorD, .memRead,
    .memWrite, .byteEnable, .extendedMem);

  branchResolve branch0 (.clk, .arstN, .state, .execLast, .instrClass, .branchKind, .outLsb,
    .branchDelay, .pcSrc);

endmodule

// File: verif/cpuControlTb_assertions.sv
`timescale 1ns/100ps

module cpuControlAssertions (
  input logic clk,
  input logic arstN,
  input cpuControlPkg::state_e state,
  input logic memRead,
  input logic memWrite,
  input logic irWrite
);
  import cpuControlPkg::*;

  // Three state bits, encoding 7 is never used
  stateLegal: assert property (@(posedge clk) disable iff (!arstN) state != 3'd7)
    else $error("State register holds the unused encoding 7");

  strobeExclusive: assert property (@(posedge clk) disable iff (!arstN) !(memRead && memWrite))
    else $error("Memory read and write strobes are high together");

  // Instruction register loads right after the fetch completes
  irWriteAfterFetch: assert property (@(posedge clk) disable iff (!arstN)
    irWrite |-> ($past(state) == fetch || $past(state) == stall))
    else $error("irWrite is high without a fetch or stall in the cycle before");

endmodule

// File: verif/cpuControlTb.sv
`timescale 1ns/100ps

module cpuControlTb;
  import cpuControlPkg::*;

  localparam int numInstr = 300;
  localparam int timeoutCycles = 400 * 12;
  // Kept opcodes plus one dropped opcode (LWL) that must act as a register op
  localparam logic [5:0] opList [23] = '{
    opRType, opJ, opJal, opBeq, opBne, opBlez, opBgtz, opAddiu, opSlti, opSltiu,
    opAndi, opOri, opXori, opLui, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw, 6'd34
  };
  localparam logic [5:0] fnList [5] = '{fnJr, fnAddu, fnAnd, fnOr, 6'd42};

  typedef struct packed {
    state_e state;
    logic active;
    logic memRead;
    logic memWrite;
    logic iorD;
    logic [3:0] byteEnable;
    extMode_e ext;
    logic regWrite;
    logic regDst;
    logic memToReg;
    logic link;
    logic pcSrc;
    srcB_e srcB;
    aluOp_e alu;
    logic branchDelay;
    logic pcWrite;
    logic irWrite;
    logic irSel;
    logic fetchRetry;
    logic srcA;
    logic aluSel;
    logic extSel;
    logic isJump;
  } expect_s;

  logic clk, arstN, execStall, waitrequest, outLsb, pcIsZero, run;
  instrWord_u instr;
  logic active, branchDelay, pcWrite, irWrite, irSel, iorD, pcSrc, fetchRetry;
  logic memRead, memWrite, aluSrcA, aluSel, extSel, regWrite, regDst, memToReg, link, isJump;
  logic [3:0] byteEnable;
  state_e state;
  extMode_e extendedMem;
  srcB_e aluSrcB;
  aluOp_e aluControl;

  // Model of the FSM, halt latch and branch delay
  state_e mState;
  logic mHalt;
  logic mDelay;
  int instrCount = 0;
  int cycleCount = 0;
  int errorCount = 0;

  cpuControl dut0 (.*);

  bind cpuControl cpuControlAssertions asrt0 (.clk(clk), .arstN(arstN), .state(state),
    .memRead(memRead), .memWrite(memWrite), .irWrite(irWrite));

  function automatic instrClass_e classOf(logic [5:0] op, logic [5:0] fn);
    case (op)
      opRType: return (fn == fnJr) ? clsJumpReg : clsAluReg;
      opAddiu, opAndi, opOri, opXori: return clsAluImm;
      opSlti, opSltiu: return clsSltImm;
      opLui: return clsLui;
      opLw, opLh, opLhu, opLb, opLbu: return clsLoad;
      opSw, opSh, opSb: return clsStore;
      opBeq, opBne, opBlez, opBgtz: return clsBranch;
      opJ: return clsJump;
      opJal: return clsJumpLink;
      default: return clsAluReg;
    endcase
  endfunction

  function automatic state_e lastExecOf(instrClass_e cls);
    case (cls)
      clsBranch, clsJump, clsJumpReg: return exec1;
      clsLoad: return exec3;
      default: return exec2;
    endcase
  endfunction

  function automatic aluOp_e aluOpOf(logic [5:0] op);
    case (op)
      opAndi: return aluAnd;
      opOri: return aluOr;
      opXori: return aluXor;
      opSlti: return aluSlt;
      opSltiu: return aluSltu;
      opLui: return aluLui;
      opBeq, opBne: return aluEq;
      opBlez, opBgtz: return aluLez;
      default: return aluAdd;
    endcase
  endfunction

  function automatic expect_s expectedOutputs(state_e s, logic [5:0] op, logic [5:0] fn,
                                              logic delay);
    expect_s e;
    instrClass_e cls;
    logic [3:0] lanes;
    extMode_e ext;
    cls = classOf(op, fn);
    e = '0;
    e.state = s;
    e.active = (s != halted);
    e.byteEnable = 4'b1111;
    e.pcSrc = delay && (s == fetch);
    e.branchDelay = delay;
    e.pcWrite = (s == fetch);
    e.irWrite = (s == decode);
    e.irSel = (s != decode);
    e.fetchRetry = (s == stall);
    lanes = (op == opLb || op == opLbu || op == opSb) ? 4'b0001 :
            (op == opLh || op == opLhu || op == opSh) ? 4'b0011 : 4'b1111;
    ext = (op == opLb) ? extByteSigned : ((op == opLh) ? extHalfSigned : extZero);
    case (s)
      fetch: begin
        e.memRead = 1'b1;
        e.srcB = srcBFour;
        e.alu = aluAdd;
      end
      stall: e.memRead = 1'b1;
      decode: begin
        e.srcB = srcBImmShift;
        e.alu = (cls == clsJump || cls == clsJumpLink) ? aluJumpTarget : aluBranchTarget;
        e.extSel = (cls == clsJump || cls == clsJumpLink);
      end
      exec1: begin
        case (cls)
          clsAluReg: begin
            e.srcA = 1'b1;
            e.alu = aluFunct;
          end
          clsLoad, clsStore: begin
            e.srcA = 1'b1;
            e.srcB = srcBImm;
            e.alu = aluAdd;
          end
          clsAluImm, clsSltImm, clsLui: begin
            e.srcA = 1'b1;
            e.srcB = srcBImm;
            e.alu = aluOpOf(op);
            e.extSel = (cls == clsAluImm);
          end
          clsBranch: begin
            e.srcA = 1'b1;
            e.alu = aluOpOf(op);
            e.aluSel = 1'b1;
          end
          clsJump: begin
            e.srcB = srcBImmShift;
            e.alu = aluJumpTarget;
            e.extSel = 1'b1;
            e.isJump = 1'b1;
          end
          clsJumpReg: begin
            e.srcA = 1'b1;
            e.alu = aluPassA;
          end
          default: begin
            e.srcB = srcBFour;
            e.alu = aluAdd;
            e.regWrite = 1'b1;
            e.memToReg = 1'b1;
            e.link = 1'b1;
          end
        endcase
      end
      exec2: begin
        if (cls == clsJumpLink) begin
          e.srcB = srcBImmShift;
          e.alu = aluJumpTarget;
          e.extSel = 1'b1;
          e.isJump = 1'b1;
        end else if (cls == clsLoad || cls == clsStore) begin
          e.memRead = (cls == clsLoad);
          e.memWrite = (cls == clsStore);
          e.iorD = 1'b1;
          e.byteEnable = lanes;
          e.ext = (cls == clsLoad) ? ext : extZero;
        end else begin
          e.regWrite = 1'b1;
          e.memToReg = 1'b1;
          e.aluSel = 1'b1;
          e.regDst = (cls == clsAluReg);
        end
      end
      exec3: begin
        e.regWrite = 1'b1;
        e.byteEnable = lanes;
        e.ext = ext;
      end
      default: ;
    endcase
    return e;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    assert (expVal === actVal) else begin
      errorCount++;
      $display("FAIL time %0t signal %s expected %0h actual %0h", $time, name, expVal, actVal);
      $display("SIMULATION FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Predicted state, taken from the rules of the FSM
  always @(posedge clk or negedge arstN) begin
    state_e last;
    state_e done;
    logic taken;
    if (!arstN) begin
      mState <= halted;
      mHalt <= 1'b0;
      mDelay <= 1'b0;
    end else begin
      last = lastExecOf(classOf(instr.rFields.opcode, instr.rFields.funct));
      done = mHalt ? halted : fetch;
      taken = (instr.iFields.opcode == opBeq || instr.iFields.opcode == opBlez) ? outLsb : !outLsb;
      if (mState == last) begin
        case (classOf(instr.rFields.opcode, instr.rFields.funct))
          clsBranch: mDelay <= taken;
          clsJump, clsJumpLink, clsJumpReg: mDelay <= 1'b1;
          default: mDelay <= 1'b0;
        endcase
      end
      if (mState == fetch) begin
        mHalt <= pcIsZero;
      end
      case (mState)
        fetch, stall: mState <= waitrequest ? stall : decode;
        decode: mState <= exec1;
        exec1: begin
          if (!execStall) begin
            mState <= (last == exec1) ? done : exec2;
          end
        end
        exec2: begin
          if (!waitrequest) begin
            mState <= (last == exec2) ? done : exec3;
          end
        end
        exec3: mState <= done;
        default: begin
          if (run) begin
            mState <= fetch;
          end
        end
      endcase
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    expect_s e;
    e = expectedOutputs(mState, instr.rFields.opcode, instr.rFields.funct, mDelay);
    checkValue("state", 32'(e.state), 32'(state));
    checkValue("active", 32'(e.active), 32'(active));
    checkValue("memRead", 32'(e.memRead), 32'(memRead));
    checkValue("memWrite", 32'(e.memWrite), 32'(memWrite));
    checkValue("iorD", 32'(e.iorD), 32'(iorD));
    checkValue("byteEnable", 32'(e.byteEnable), 32'(byteEnable));
    checkValue("extendedMem", 32'(e.ext), 32'(extendedMem));
    checkValue("regWrite", 32'(e.regWrite), 32'(regWrite));
    checkValue("regDst", 32'(e.regDst), 32'(regDst));
    checkValue("memToReg", 32'(e.memToReg), 32'(memToReg));
    checkValue("link", 32'(e.link), 32'(link));
    checkValue("pcSrc", 32'(e.pcSrc), 32'(pcSrc));
    checkValue("aluSrcB", 32'(e.srcB), 32'(aluSrcB));
    checkValue("aluControl", 32'(e.alu), 32'(aluControl));
    checkValue("branchDelay", 32'(e.branchDelay), 32'(branchDelay));
    checkValue("pcWrite", 32'(e.pcWrite), 32'(pcWrite));
    checkValue("irWrite", 32'(e.irWrite), 32'(irWrite));
    checkValue("irSel", 32'(e.irSel), 32'(irSel));
    checkValue("fetchRetry", 32'(e.fetchRetry), 32'(fetchRetry));
    checkValue("aluSrcA", 32'(e.srcA), 32'(aluSrcA));
    checkValue("aluSel", 32'(e.aluSel), 32'(aluSel));
    checkValue("extSel", 32'(e.extSel), 32'(extSel));
    checkValue("isJump", 32'(e.isJump), 32'(isJump));
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    int opIdx;
    int fnIdx;
    void'($urandom(32'hdd6cc570));
    arstN = 1'b0;
    instr = '0;
    execStall = 1'b0;
    waitrequest = 1'b0;
    outLsb = 1'b0;
    pcIsZero = 1'b0;
    run = 1'b0;
    repeat (5) @(posedge clk);
    #10;
    arstN = 1'b1;
    while (instrCount < numInstr) begin
      @(posedge clk);
      #10;
      waitrequest = ($urandom % 4) == 0;
      execStall = ($urandom % 4) == 0;
      outLsb = ($urandom % 2) != 0;
      pcIsZero = ($urandom % 16) == 0;
      run = ($urandom % 3) == 0;
      // New instruction word only while fetching
      if (mState == fetch) begin
        opIdx = $urandom % 23;
        fnIdx = $urandom % 5;
        instr = {opList[opIdx], 20'($urandom), fnList[fnIdx]};
        instrCount++;
      end
    end
    @(posedge clk);
    #10;
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
source/cpuControlPkg.sv
source/instrClassify.sv
source/controlFsm.sv
source/datapathSelect.sv
source/memAccessDecode.sv
source/branchResolve.sv
source/cpuControl.sv
verif/cpuControlTb_assertions.sv
verif/cpuControlTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuControlTb -f compile.f -o cpuControlSim
./obj_dir/cpuControlSim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation finished cleanly"
